/* filelist.f */
design/csr_map_pkg.sv
design/engine_pkg.sv
design/csr_mgr.sv
design/accum_engine.sv
design/accel_top.sv
verif/tb_clock.sv
verif/accel_props.sv
verif/accel_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run accel_tb and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module accel_tb -o accel_sim
	./obj_dir/accel_sim | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG) || ! grep -q "\*\* PASS \*\*" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* verif/accel_tb.sv */
/*
 * Testbench for the accelerator top level
 *   MMIO write, read and polling tasks
 *   Reference values for headers and engine registers
 *   Response checking assertions, watchdog and closing result
 */

`timescale 1ns/100ps
`default_nettype none

module accel_tb;

    import csr_map_pkg::*;
    import engine_pkg::*;

    // Cycle budget of each test, used by the watchdog
    localparam int LONG_LIMIT     = 100;
    localparam int HDR_CYCLES     = 40;
    localparam int REGS_CYCLES    = 400;
    localparam int ENABLE_CYCLES  = 400;
    localparam int DISABLE_CYCLES = 60;
    localparam int COUNT_CYCLES   = 500 + LONG_LIMIT;
    localparam int BURST_CYCLES   = 40;
    localparam int MARGIN_CYCLES  = 1000;
    localparam int MAX_POLLS      = 60;

    logic         clk;
    logic         reset_n;
    mmio_wr_t     mmio_wr;
    mmio_rd_req_t mmio_rd_req;
    mmio_rd_rsp_t mmio_rd_rsp;

    int errors  = 0;
    int checked = 0;
    int seed    = 32'ha5f0;
    int rd_seq  = 0;
    int rsp_count = 0;

    // Expectations and responses indexed by tag
    mmio_data_t exp_mem [512];
    logic       chk_mem [512];
    string      name_mem [512];
    mmio_data_t rsp_mem [512];

    mmio_data_t step_ref [NUM_ENGINES];
    mmio_data_t limit_ref [NUM_ENGINES];
    mmio_data_t head_exp;
    logic       head_chk;
    mmio_tid_t  exp_tid;

    tb_clock i_tb_clock (.clk(clk), .reset_n(reset_n));

    accel_top i_accel_top
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .mmio_wr     (mmio_wr),
        .mmio_rd_req (mmio_rd_req),
        .mmio_rd_rsp (mmio_rd_rsp)
    );

    // ========================================
    // Response checking
    // ========================================

    assign head_exp = exp_mem[mmio_rd_rsp.tid];
    assign head_chk = chk_mem[mmio_rd_rsp.tid];
    assign exp_tid  = rsp_count[8:0];

    always @(posedge clk)
    begin
        if (reset_n && mmio_rd_rsp.valid)
        begin
            rsp_mem[mmio_rd_rsp.tid] <= mmio_rd_rsp.data;
            rsp_count <= rsp_count + 1;
        end
    end

    // Responses come back in issue order
    assert property (@(posedge clk) disable iff (!reset_n)
        mmio_rd_rsp.valid |-> (mmio_rd_rsp.tid == exp_tid))
    else
    begin
        errors++;
        $display("Read response arrived with tag %0d out of order", $sampled(mmio_rd_rsp.tid));
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        mmio_rd_rsp.valid |-> (!head_chk || (mmio_rd_rsp.data == head_exp)))
    else
    begin
        errors++;
        $display("[ERROR] %s: expected %h, actual %h", name_mem[$sampled(mmio_rd_rsp.tid)],
                 $sampled(head_exp), $sampled(mmio_rd_rsp.data));
    end

    // ========================================
    // Stimulus tasks
    // ========================================

    function automatic csr_idx_t eng_addr(input int e, input int r);
        return csr_idx_t'(12'h100 + e * 16 + r);
    endfunction

    task automatic write_reg(input csr_idx_t idx, input mmio_data_t data);
        @(posedge clk);
        mmio_wr <= {1'b1, mmio_addr_t'(idx), data};
        @(posedge clk);
        mmio_wr.write <= 1'b0;
    endtask

    // Leaves the strobe high so that calls in a row issue one read per cycle
    task automatic issue_read(input csr_idx_t idx, input mmio_data_t exp, input logic chk,
                              input string name);
        mmio_tid_t tid;
        tid = rd_seq[8:0];
        @(posedge clk);
        exp_mem[tid]  = exp;
        chk_mem[tid]  = chk;
        name_mem[tid] = name;
        mmio_rd_req <= {1'b1, mmio_addr_t'(idx), tid};
        rd_seq++;
        if (chk)
        begin
            checked++;
        end
    endtask

    task automatic end_reads();
        @(posedge clk);
        mmio_rd_req.read <= 1'b0;
    endtask

    task automatic check_read(input csr_idx_t idx, input mmio_data_t exp, input string name);
        issue_read(idx, exp, 1'b1, name);
        end_reads();
    endtask

    task automatic fetch(input csr_idx_t idx, output mmio_data_t data);
        int seq;
        issue_read(idx, '0, 1'b0, "poll");
        end_reads();
        seq = rd_seq - 1;
        while (rsp_count <= seq)
        begin
            @(posedge clk);
        end
        data = rsp_mem[seq[8:0]];
    endtask

    task automatic wait_value(input csr_idx_t idx, input mmio_data_t value, input string name);
        mmio_data_t data;
        int polls;
        polls = 0;
        fetch(idx, data);
        while ((data != value) && (polls < MAX_POLLS))
        begin
            fetch(idx, data);
            polls++;
        end
        if (data != value)
        begin
            errors++;
            $display("Gave up waiting for %s to reach %h", name, value);
        end
    endtask

    // Engines listed in the mask ran to their limit from zero
    task automatic check_done(input logic [NUM_ENGINES-1:0] mask, input string name);
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            if (mask[e])
            begin
                check_read(eng_addr(e, REG_ACCUM), step_ref[e] * limit_ref[e], name);
                check_read(eng_addr(e, REG_ITER), limit_ref[e], name);
                check_read(eng_addr(e, REG_STATUS), 64'd2, name);
            end
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        mmio_wr     = '0;
        mmio_rd_req = '0;
        wait (reset_n);
        @(posedge clk);

        // Header, ID and configuration
        check_read(CSR_DFH, (64'h1 << 60) | (64'h1 << 40), "header");
        check_read(CSR_ID_L, ACCEL_ID_L, "id_low");
        check_read(CSR_ID_H, ACCEL_ID_H, "id_high");
        check_read(CSR_CONFIG, mmio_data_t'((CLK_FREQ_MHZ << 8) | NUM_ENGINES), "config");

        // Step and limit per engine, then writes that must change nothing
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            step_ref[e]  = {$random(seed), $random(seed)};
            limit_ref[e] = mmio_data_t'(1 + ($unsigned($random(seed)) % 32));
            write_reg(eng_addr(e, REG_STEP), step_ref[e]);
            write_reg(eng_addr(e, REG_LIMIT), limit_ref[e]);
        end
        write_reg(eng_addr(0, REG_ACCUM), 64'hdead_0001);
        write_reg(eng_addr(1, REG_ITER), 64'hdead_0002);
        write_reg(eng_addr(2, REG_STATUS), 64'h3);
        write_reg(12'h050, 64'hdead_0003);
        write_reg(12'h150, 64'hdead_0004);
        write_reg(12'h180, 64'hdead_0005);
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            check_read(eng_addr(e, REG_STEP), step_ref[e], "step_readback");
            check_read(eng_addr(e, REG_LIMIT), limit_ref[e], "limit_readback");
            check_read(eng_addr(e, REG_ACCUM), '0, "accum_idle");
            check_read(eng_addr(e, REG_ITER), '0, "iter_idle");
            check_read(eng_addr(e, 5), '0, "unused_index");
        end
        check_read(12'h050, '0, "unmapped");
        check_read(12'h140, '0, "missing_engine");
        check_read(12'h150, '0, "missing_engine");
        check_read(12'h180, '0, "unmapped_engine_area");

        // Enable engines 0 and 2 and let them finish
        write_reg(CSR_ENG_ENABLE, 64'h5);
        wait_value(CSR_RUN_FLAGS, 64'h5, "run flags");
        wait_value(CSR_ACTIVE_FLAGS, '0, "active flags");
        check_read(CSR_RUN_FLAGS, 64'h5, "run_flags");
        check_done(4'b0101, "enable_result");
        check_read(eng_addr(1, REG_ACCUM), '0, "not_enabled");

        // Disable one engine, then the other
        write_reg(CSR_ENG_DISABLE, 64'h1);
        check_read(CSR_RUN_FLAGS, 64'h4, "disable_one");
        write_reg(CSR_ENG_DISABLE, 64'h4);
        check_read(CSR_RUN_FLAGS, 64'h0, "disable_all");

        // Long run on engine 0 from idle, engine 1 enabled mid run with no work
        step_ref[0]  = {$random(seed), $random(seed)};
        limit_ref[0] = mmio_data_t'(LONG_LIMIT);
        limit_ref[1] = '0;
        write_reg(eng_addr(0, REG_STEP), step_ref[0]);
        write_reg(eng_addr(0, REG_LIMIT), limit_ref[0]);
        write_reg(eng_addr(1, REG_LIMIT), limit_ref[1]);
        write_reg(CSR_ENG_ENABLE, 64'h1);
        wait_value(CSR_RUN_FLAGS, 64'h1, "run flags");
        write_reg(CSR_ENG_ENABLE, 64'h2);
        wait_value(CSR_RUN_FLAGS, 64'h3, "run flags");
        wait_value(CSR_ACTIVE_FLAGS, '0, "active flags");
        check_read(CSR_ACTIVE_CYCLES, mmio_data_t'(LONG_LIMIT), "active_cycles");
        check_done(4'b0001, "restart_result");
        check_read(eng_addr(1, REG_ACCUM), '0, "zero_limit");

        // Reads on consecutive cycles
        issue_read(CSR_ID_L, ACCEL_ID_L, 1'b1, "burst_id_low");
        issue_read(CSR_ID_H, ACCEL_ID_H, 1'b1, "burst_id_high");
        issue_read(CSR_RUN_FLAGS, 64'h3, 1'b1, "burst_run_flags");
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            issue_read(eng_addr(e, REG_STEP), step_ref[e], 1'b1, "burst_step");
            issue_read(eng_addr(e, REG_LIMIT), limit_ref[e], 1'b1, "burst_limit");
        end
        end_reads();

        while (rsp_count < rd_seq)
        begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("Checked reads: %0d, errors: %0d", checked, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the test budgets
    initial
    begin
        repeat (HDR_CYCLES + REGS_CYCLES + ENABLE_CYCLES + DISABLE_CYCLES + COUNT_CYCLES +
                BURST_CYCLES + MARGIN_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/accel_props.sv */
/*
 * Protocol assertions for the accelerator top level
 *   Read response timing and tag
 *   Idle outputs right after reset
 *   state_run rising only as state_reset falls
 */

`timescale 1ns/100ps
`default_nettype none

module accel_props
(
    input logic                      clk,
    input logic                      reset_n,
    input csr_map_pkg::mmio_rd_req_t mmio_rd_req,
    input csr_map_pkg::mmio_rd_rsp_t mmio_rd_rsp,
    input engine_pkg::eng_ctrl_t     eng_ctrl [engine_pkg::NUM_ENGINES]
);

    import engine_pkg::*;

    // Flattened views of the per-engine control bundles
    logic [NUM_ENGINES-1:0] wr_vec;
    logic [NUM_ENGINES-1:0] reset_vec;
    logic [NUM_ENGINES-1:0] run_vec;

    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_flat
        assign wr_vec[e]    = eng_ctrl[e].wr_req;
        assign reset_vec[e] = eng_ctrl[e].state_reset;
        assign run_vec[e]   = eng_ctrl[e].state_run;
    end

    // ========================================
    // Read response
    // ========================================

    // Input register plus two stages, so the answer is seen three edges after the strobe
    assert property (@(posedge clk) disable iff (!reset_n)
        mmio_rd_req.read |-> ##3
            (mmio_rd_rsp.valid && (mmio_rd_rsp.tid == $past(mmio_rd_req.tid, 3))))
        else $error("read response missing or carrying a wrong tag");

    // All strobes and run states are quiet when reset is let go
    assert property (@(posedge clk)
        $rose(reset_n) |-> (!mmio_rd_rsp.valid && (wr_vec == '0) && (run_vec == '0)))
        else $error("outputs active in the first cycle after reset");

    // An engine only starts running as it leaves its reset hold
    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_run
        assert property (@(posedge clk) disable iff (!reset_n)
            $rose(run_vec[e]) |-> ($past(reset_vec[e]) && !reset_vec[e]))
            else $error("engine %0d started without a reset hold", e);
    end

endmodule

bind accel_top accel_props i_accel_props
(
    .clk         (clk),
    .reset_n     (reset_n),
    .mmio_rd_req (mmio_rd_req),
    .mmio_rd_rsp (mmio_rd_rsp),
    .eng_ctrl    (eng_ctrl)
);

`default_nettype wire

/* verif/tb_clock.sv */
/*
 * Testbench clock and reset
 *   40 ns clock
 *   Active low reset held for the first 2 cycles
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk     = 1'b0;
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    end

    // Half of the 40 ns period
    always #20 clk = ~clk;

endmodule

`default_nettype wire

/* design/accel_top.sv */
/*
 * Accelerator top level
 *   CSR manager instance
 *   Row of accumulation engines built by a generate loop
 */

`timescale 1ns/100ps
`default_nettype none

module accel_top
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  csr_map_pkg::mmio_wr_t     mmio_wr,
    input  csr_map_pkg::mmio_rd_req_t mmio_rd_req,
    output csr_map_pkg::mmio_rd_rsp_t mmio_rd_rsp
);

    import engine_pkg::*;

    // One control and one status bundle per engine
    eng_ctrl_t   eng_ctrl [NUM_ENGINES];
    eng_status_t eng_status [NUM_ENGINES];

    csr_mgr i_csr_mgr
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .mmio_wr     (mmio_wr),
        .mmio_rd_req (mmio_rd_req),
        .mmio_rd_rsp (mmio_rd_rsp),
        .eng_ctrl    (eng_ctrl),
        .eng_status  (eng_status)
    );

    // ========================================
    // Engines
    // ========================================

    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_engine
        accum_engine i_accum_engine
        (
            .clk     (clk),
            .reset_n (reset_n),
            .ctrl    (eng_ctrl[e]),
            .status  (eng_status[e])
        );
    end

endmodule

`default_nettype wire

/* design/accum_engine.sv */
/*
 * Accumulation engine
 *   Writable step and limit registers
 *   Accumulator and iteration count driven by state_reset and state_run
 *   Register view returned to the CSR manager
 */

`timescale 1ns/100ps
`default_nettype none

module accum_engine
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  engine_pkg::eng_ctrl_t   ctrl,
    output engine_pkg::eng_status_t status
);

    import csr_map_pkg::*;
    import engine_pkg::*;

    mmio_data_t step;
    mmio_data_t limit;
    mmio_data_t accum;
    mmio_data_t iter;
    logic       active;

    // Works only while running, out of reset and short of the limit
    assign active = ctrl.state_run && !ctrl.state_reset && (iter < limit);

    // ========================================
    // Host writable registers
    // ========================================

    // Accumulator, iteration count and status are read only from the host
    always_ff @(posedge clk)
    begin
        if (ctrl.wr_req && (ctrl.wr_idx == REG_STEP))
        begin
            step <= ctrl.wr_data;
        end
        if (ctrl.wr_req && (ctrl.wr_idx == REG_LIMIT))
        begin
            limit <= ctrl.wr_data;
        end

        if (!reset_n)
        begin
            step  <= '0;
            limit <= '0;
        end
    end

    // ========================================
    // Accumulation
    // ========================================

    always_ff @(posedge clk)
    begin
        if (ctrl.state_reset)
        begin
            accum <= '0;
            iter  <= '0;
        end
        else if (active)
        begin
            accum <= accum + step;
            iter  <= iter + 64'd1;
        end

        if (!reset_n)
        begin
            accum <= '0;
            iter  <= '0;
        end
    end

    // Unused register slots read as zero
    always_comb
    begin
        status.status_active        = active;
        status.rd_data              = '0;
        status.rd_data[REG_STEP]    = step;
        status.rd_data[REG_LIMIT]   = limit;
        status.rd_data[REG_ACCUM]   = accum;
        status.rd_data[REG_ITER]    = iter;
        // Bit 0 is the active flag and bit 1 the run flag
        status.rd_data[REG_STATUS]  = {62'b0, ctrl.state_run, active};
    end

endmodule

`default_nettype wire

/* design/csr_mgr.sv */
/*
 * CSR manager for the accelerator register window
 *   Read path with an input register and two reduction stages
 *   Registered write fanout to the engine register spaces
 *   Enable and disable FSM driving state_reset and state_run
 *   Active-cycle counter
 */

`timescale 1ns/100ps
`default_nettype none

module csr_mgr
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  csr_map_pkg::mmio_wr_t     mmio_wr,
    input  csr_map_pkg::mmio_rd_req_t mmio_rd_req,
    output csr_map_pkg::mmio_rd_rsp_t mmio_rd_rsp,
    output engine_pkg::eng_ctrl_t     eng_ctrl [engine_pkg::NUM_ENGINES],
    input  engine_pkg::eng_status_t   eng_status [engine_pkg::NUM_ENGINES]
);

    import csr_map_pkg::*;
    import engine_pkg::*;

    typedef enum logic [1:0] {
        STATE_READY      = 2'h0,
        STATE_HOLD_RESET = 2'h1,
        STATE_ENG_START  = 2'h2
    } state_t;

    state_t state;
    logic [3:0] hold_cnt;

    // Engine state owned by the FSM, plus the sampled active flags
    logic [NUM_ENGINES-1:0] state_reset;
    logic [NUM_ENGINES-1:0] state_run;
    logic [NUM_ENGINES-1:0] status_active;

    logic        some_engine_enabled;
    logic        some_engine_active;
    logic        cycle_cnt_clear;
    logic [47:0] active_cycles;

    // ========================================
    // Read path
    // ========================================

    // Input register for the read request
    logic      rd_req_q;
    csr_idx_t  rd_idx_q;
    mmio_tid_t rd_tid_q;

    always_ff @(posedge clk)
    begin
        rd_req_q <= mmio_rd_req.read;
        rd_idx_q <= mmio_rd_req.addr[11:0];
        rd_tid_q <= mmio_rd_req.tid;

        if (!reset_n)
        begin
            rd_req_q <= 1'b0;
        end
    end

    // Stage 1 reduces every area to a single word using the low 4 index bits
    logic       rd_req_s1;
    csr_idx_t   rd_idx_s1;
    mmio_tid_t  rd_tid_s1;
    mmio_data_t eng_word_s1 [NUM_ENGINES];
    mmio_data_t hdr_word_s1;
    mmio_data_t ctrl_word_s1;

    always_ff @(posedge clk)
    begin
        rd_req_s1 <= rd_req_q;
        rd_idx_s1 <= rd_idx_q;
        rd_tid_s1 <= rd_tid_q;

        if (!reset_n)
        begin
            rd_req_s1 <= 1'b0;
        end
    end

    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_rd_eng
        always_ff @(posedge clk)
        begin
            eng_word_s1[e]   <= eng_status[e].rd_data[rd_idx_q[3:0]];
            status_active[e] <= eng_status[e].status_active;
        end
    end

    // Feature header and the two ID halves
    always_ff @(posedge clk)
    begin
        case (rd_idx_q[3:0])
            CSR_DFH[3:0]:  hdr_word_s1 <= ACCEL_DFH;
            CSR_ID_L[3:0]: hdr_word_s1 <= ACCEL_ID_L;
            CSR_ID_H[3:0]: hdr_word_s1 <= ACCEL_ID_H;
            default:       hdr_word_s1 <= '0;
        endcase
    end

    // Control space reads
    always_ff @(posedge clk)
    begin
        case (rd_idx_q[3:0])
            // Bits 23:8 hold the clock frequency and bits 7:0 the engine count
            CSR_CONFIG[3:0]:
            begin
                ctrl_word_s1 <= {40'b0, 16'(CLK_FREQ_MHZ), 8'(NUM_ENGINES)};
            end
            CSR_RUN_FLAGS[3:0]:     ctrl_word_s1 <= mmio_data_t'(state_run);
            CSR_ACTIVE_FLAGS[3:0]:  ctrl_word_s1 <= mmio_data_t'(status_active);
            CSR_ACTIVE_CYCLES[3:0]: ctrl_word_s1 <= mmio_data_t'(active_cycles);
            default:                ctrl_word_s1 <= '0;
        endcase
    end

    // Engine digit of the index, valid only when bit 7 is clear
    eng_idx_t   rd_eng;
    logic       rd_eng_hit;
    mmio_data_t rd_eng_word;

    assign rd_eng     = rd_idx_s1[6:4];
    assign rd_eng_hit = (rd_idx_s1[11:8] == AREA_ENG) && !rd_idx_s1[7];

    // Missing engines fall through to zero
    always_comb
    begin
        rd_eng_word = '0;
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            if (rd_eng == eng_idx_t'(e))
            begin
                rd_eng_word = eng_word_s1[e];
            end
        end
    end

    // Stage 2 picks one of the reduced words by index bits 11:4
    always_ff @(posedge clk)
    begin
        mmio_rd_rsp.valid <= rd_req_s1;
        mmio_rd_rsp.tid   <= rd_tid_s1;

        if (rd_idx_s1[11:4] == AREA_HDR)
        begin
            mmio_rd_rsp.data <= hdr_word_s1;
        end
        else if (rd_idx_s1[11:4] == AREA_CTRL)
        begin
            mmio_rd_rsp.data <= ctrl_word_s1;
        end
        else if (rd_eng_hit)
        begin
            mmio_rd_rsp.data <= rd_eng_word;
        end
        else
        begin
            mmio_rd_rsp.data <= '0;
        end

        if (!reset_n)
        begin
            mmio_rd_rsp.valid <= 1'b0;
        end
    end

    // ========================================
    // Write path
    // ========================================

    // One registered copy feeds both the engine fanout and the command decode
    mmio_wr_t wr_q;

    always_ff @(posedge clk)
    begin
        wr_q <= mmio_wr;

        if (!reset_n)
        begin
            wr_q.write <= 1'b0;
        end
    end

    eng_idx_t wr_eng;
    logic     wr_eng_hit;

    assign wr_eng     = wr_q.addr[6:4];
    assign wr_eng_hit = wr_q.write && (wr_q.addr[11:8] == AREA_ENG) && !wr_q.addr[7];

    // Each engine sees its own strobe and a registered copy of its run state
    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_wr_eng
        always_ff @(posedge clk)
        begin
            eng_ctrl[e].wr_req      <= wr_eng_hit && (wr_eng == eng_idx_t'(e));
            eng_ctrl[e].wr_idx      <= wr_q.addr[3:0];
            eng_ctrl[e].wr_data     <= wr_q.data;
            eng_ctrl[e].state_reset <= state_reset[e];
            eng_ctrl[e].state_run   <= state_run[e];

            if (!reset_n)
            begin
                eng_ctrl[e].wr_req      <= 1'b0;
                eng_ctrl[e].state_reset <= 1'b0;
                eng_ctrl[e].state_run   <= 1'b0;
            end
        end
    end

    // ========================================
    // Engine commands
    // ========================================

    // Commands are accepted only in ready, anything else is dropped
    logic is_enable;
    logic is_disable;

    assign is_enable  = (state == STATE_READY) && wr_q.write &&
                        (wr_q.addr[11:0] == CSR_ENG_ENABLE);
    assign is_disable = (state == STATE_READY) && wr_q.write &&
                        (wr_q.addr[11:0] == CSR_ENG_DISABLE);

    always_ff @(posedge clk)
    begin
        if (state == STATE_ENG_START)
        begin
            // Engines held in reset move over to run together
            state_run   <= state_run | state_reset;
            state_reset <= '0;
        end
        else if (is_enable)
        begin
            state_reset <= state_reset | wr_q.data[NUM_ENGINES-1:0];
        end
        else if (is_disable)
        begin
            state_run <= state_run & ~wr_q.data[NUM_ENGINES-1:0];
        end

        if (!reset_n)
        begin
            state_reset <= '0;
            state_run   <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        some_engine_enabled <= |state_run;
        some_engine_active  <= |status_active;
    end

    // Enable sequence holds state_reset for 16 cycles before eng_start
    always_ff @(posedge clk)
    begin
        case (state)
            STATE_READY:
            begin
                if (is_enable)
                begin
                    state    <= STATE_HOLD_RESET;
                    hold_cnt <= 4'd1;

                    // Counting restarts only when starting from idle
                    if (!some_engine_enabled)
                    begin
                        cycle_cnt_clear <= 1'b1;
                    end
                end
            end
            STATE_HOLD_RESET:
            begin
                hold_cnt <= hold_cnt + 4'd1;
                if (hold_cnt == 4'd0)
                begin
                    state           <= STATE_ENG_START;
                    cycle_cnt_clear <= 1'b0;
                end
            end
            STATE_ENG_START:
            begin
                state <= STATE_READY;
            end
            default:
            begin
                state <= STATE_READY;
            end
        endcase

        if (!reset_n)
        begin
            state           <= STATE_READY;
            hold_cnt        <= 4'd0;
            cycle_cnt_clear <= 1'b0;
        end
    end

    // Counts every cycle in which at least one engine did work
    always_ff @(posedge clk)
    begin
        if (cycle_cnt_clear)
        begin
            active_cycles <= '0;
        end
        else if (some_engine_active)
        begin
            active_cycles <= active_cycles + 48'd1;
        end

        if (!reset_n)
        begin
            active_cycles <= '0;
        end
    end

endmodule

`default_nettype wire

/* design/engine_pkg.sv */
/*
 * Engine side definitions
 *   Engine count and engine index type
 *   Register indexes inside one engine's 16-word space
 *   Control and status structs between the CSR manager and the engines
 */

`default_nettype none

package engine_pkg;

    import csr_map_pkg::*;

    // Between 1 and 8 engines fit in the 0x1x? window
    localparam int NUM_ENGINES = 4;

    typedef logic [2:0] eng_idx_t;

    // ========================================
    // Engine register indexes
    // ========================================

    localparam logic [3:0] REG_STEP   = 4'd0;
    localparam logic [3:0] REG_LIMIT  = 4'd1;
    localparam logic [3:0] REG_ACCUM  = 4'd2;
    localparam logic [3:0] REG_ITER   = 4'd3;
    localparam logic [3:0] REG_STATUS = 4'd4;

    // Commands from the manager to one engine
    typedef struct packed {
        logic       wr_req;
        logic [3:0] wr_idx;
        mmio_data_t wr_data;
        logic       state_reset;
        logic       state_run;
    } eng_ctrl_t;

    // The full register view of one engine, reduced by the manager on a read
    typedef struct packed {
        logic                    status_active;
        mmio_data_t [15:0]       rd_data;
    } eng_status_t;

endpackage

`default_nettype wire

/* design/csr_map_pkg.sv */
/*
 * MMIO register window definitions
 *   Word, address, tag and register index types
 *   Feature header and accelerator ID constants
 *   Area codes and control space register indexes
 *   MMIO write, read request and read response structs
 */

`default_nettype none

package csr_map_pkg;

    // The host addresses 64-bit words and only bits 11:0 are decoded
    typedef logic [15:0] mmio_addr_t;
    typedef logic [63:0] mmio_data_t;
    typedef logic [8:0]  mmio_tid_t;
    typedef logic [11:0] csr_idx_t;

    // ========================================
    // Identification
    // ========================================

    // Feature type 1 (accelerator) with the end-of-list bit 40 set and no next feature
    localparam mmio_data_t ACCEL_DFH  = {4'h1, 19'b0, 1'b1, 24'h0, 16'h0};
    localparam mmio_data_t ACCEL_ID_L = 64'h9c1e_53a7_44d2_0b6f;
    localparam mmio_data_t ACCEL_ID_H = 64'h3f8a_d61c_27e4_4b95;

    // Reported in the configuration word since there is no second clock to measure against
    localparam int CLK_FREQ_MHZ = 25;

    // ========================================
    // Address map
    // ========================================

    // Areas are selected by index bits 11:4, engines by bits 11:8 plus the engine digit
    localparam logic [7:0] AREA_HDR  = 8'h00;
    localparam logic [7:0] AREA_CTRL = 8'h01;
    localparam logic [3:0] AREA_ENG  = 4'h1;

    localparam csr_idx_t CSR_DFH  = 12'h000;
    localparam csr_idx_t CSR_ID_L = 12'h001;
    localparam csr_idx_t CSR_ID_H = 12'h002;

    // Control space writes
    localparam csr_idx_t CSR_ENG_ENABLE  = 12'h010;
    localparam csr_idx_t CSR_ENG_DISABLE = 12'h011;

    // Control space reads
    localparam csr_idx_t CSR_CONFIG        = 12'h010;
    localparam csr_idx_t CSR_RUN_FLAGS     = 12'h011;
    localparam csr_idx_t CSR_ACTIVE_FLAGS  = 12'h012;
    localparam csr_idx_t CSR_ACTIVE_CYCLES = 12'h013;

    typedef struct packed {
        logic       write;
        mmio_addr_t addr;
        mmio_data_t data;
    } mmio_wr_t;

    typedef struct packed {
        logic       read;
        mmio_addr_t addr;
        mmio_tid_t  tid;
    } mmio_rd_req_t;

    typedef struct packed {
        logic       valid;
        mmio_data_t data;
        mmio_tid_t  tid;
    } mmio_rd_rsp_t;

endpackage

`default_nettype wire
